//--- Bender.yml
package:
  name: cpu16

sources:
  - files:
      - design/cpu_pkg.sv
      - design/instr_reg.sv
      - design/reg_file.sv
      - design/alu.sv
      - design/unified_memory.sv
      - design/status_reg.sv
      - design/pc_unit.sv
      - design/control_fsm.sv
      - design/data_path.sv
      - design/cpu_top.sv
  - target: test
    files:
      - testbench/tb_cpu_top.sv

//--- design/alu.sv
// Combinational; flags are always computed, the status register decides which ones it keeps
`timescale 1ns/1ps

module alu (
    input  logic [cpu_pkg::DATA_W-1:0]  a,
    input  logic [cpu_pkg::DATA_W-1:0]  b,
    input  cpu_pkg::opcode_e            select,
    output logic [cpu_pkg::DATA_W-1:0]  out,
    output logic                        c,  // Carry, or borrow on SUB
    output logic                        l,  // Unsigned a < b
    output logic                        f,  // Signed overflow
    output logic                        z,
    output logic                        n   // Signed a < b
);
    import cpu_pkg::*;

    logic [DATA_W:0] sum;
    logic [DATA_W:0] diff;
    logic            sum_ovf;
    logic            diff_ovf;

    assign sum  = {1'b0, a} + {1'b0, b};
    assign diff = {1'b0, a} - {1'b0, b};

    // Same-sign operands, result sign flips
    assign sum_ovf  = (a[DATA_W-1] == b[DATA_W-1]) && (sum[DATA_W-1] != a[DATA_W-1]);
    assign diff_ovf = (a[DATA_W-1] != b[DATA_W-1]) && (diff[DATA_W-1] != a[DATA_W-1]);

    always_comb begin
        out = sum[DATA_W-1:0];  // ADD, ADDI, LOAD, STORE and the rest
        c   = sum[DATA_W];
        f   = sum_ovf;
        case (select)
            SUB, CMP: begin
                out = diff[DATA_W-1:0];
                c   = diff[DATA_W];
                f   = diff_ovf;
            end
            AND: out = a & b;
            OR:  out = a | b;
            XOR: out = a ^ b;
            SHL: out = a << b[3:0];  // Shift by low 4 bits only
            SHR: out = a >> b[3:0];  // Logical
            default: ;
        endcase
    end

    assign l = a < b;
    assign n = $signed(a) < $signed(b);
    assign z = (out == '0);  // Equal operands on CMP

endmodule

//--- design/control_fsm.sv
// Three cycles per instruction, four for LOAD; start is only taken in IDLE or HALT
`timescale 1ns/1ps

module control_fsm (
    input  logic            clk,
    input  logic            reset,
    input  logic            start,
    input  cpu_pkg::instr_u instr,
    input  cpu_pkg::psr_t   psr,
    output cpu_pkg::ctrl_t  ctrl,
    output logic            halted
);
    import cpu_pkg::*;

    state_e state_q;
    state_e state_d;

    always_ff @(posedge clk) begin
        if (reset) state_q <= ST_IDLE;
        else       state_q <= state_d;
    end

    always_comb begin
        ctrl    = '0;
        state_d = state_q;
        case (state_q)
            ST_IDLE, ST_HALT: begin
                ctrl.host_own = 1'b1;
                if (start) begin
                    ctrl.pc_en        = 1'b1;  // Clear PC
                    ctrl.pc_addr_mode = HOLD_ZERO;
                    state_d           = ST_FETCH;
                end
            end
            ST_FETCH: state_d = ST_DECODE;  // Port 2 reads mem[pc]
            ST_DECODE: begin
                ctrl.instr_en     = 1'b1;
                ctrl.pc_en        = 1'b1;
                ctrl.pc_addr_mode = INCR;
                state_d           = ST_EXEC;
            end
            ST_EXEC: begin
                state_d = ST_FETCH;
                case (instr.r.opcode)
                    ADD, SUB: begin
                        ctrl.wr_en   = 1'b1;
                        ctrl.of_f_en = 1'b1;
                        ctrl.z_f_en  = 1'b1;
                    end
                    ADDI: begin
                        ctrl.wr_en   = 1'b1;
                        ctrl.alu_src = 1'b1;
                        ctrl.of_f_en = 1'b1;
                        ctrl.z_f_en  = 1'b1;
                    end
                    AND, OR, XOR, SHL, SHR: begin
                        ctrl.wr_en  = 1'b1;
                        ctrl.z_f_en = 1'b1;
                    end
                    CMP: begin
                        ctrl.cmp_f_en = 1'b1;
                        ctrl.z_f_en   = 1'b1;
                    end
                    LOAD: begin
                        ctrl.alu_src = 1'b1;  // Address ra + imm4 on port 1
                        state_d      = ST_MEM;
                    end
                    STORE: begin
                        ctrl.alu_src   = 1'b1;
                        ctrl.mem_wr_en = 1'b1;  // Data is rb
                    end
                    JMP: begin
                        ctrl.pc_en        = 1'b1;
                        ctrl.pc_addr_mode = REL12;
                    end
                    BEQ: begin
                        ctrl.pc_en        = psr.z;  // Not taken keeps PC
                        ctrl.pc_addr_mode = REL4;
                    end
                    HALT:    state_d = ST_HALT;
                    default: ;  // NOP and unused codes
                endcase
            end
            ST_MEM: begin
                ctrl.alu_src        = 1'b1;  // Hold the load address
                ctrl.wr_en          = 1'b1;
                ctrl.write_back_sel = 1'b1;
                state_d             = ST_FETCH;
            end
            default: state_d = ST_IDLE;
        endcase
    end

    assign halted = (state_q == ST_HALT);

    a_state_legal: assert property (@(posedge clk) disable iff (reset)
        state_q inside {ST_IDLE, ST_FETCH, ST_DECODE, ST_EXEC, ST_MEM, ST_HALT})
        else $error("control_fsm: illegal state %0d", state_q);

    // Register write and memory write belong to different instructions
    a_wr_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(ctrl.mem_wr_en && ctrl.wr_en))
        else $error("control_fsm: register and memory write in one cycle");

endmodule

//--- design/cpu_pkg.sv
// ISA is fixed at 16 bits; host addresses are 10 bits, so at most 1024 words are reachable
package cpu_pkg;

    localparam int DATA_W = 16;  // Word width, fixed by the ISA

    // Opcode also serves as the ALU select
    typedef enum logic [3:0] {
        ADD   = 4'h0,
        SUB   = 4'h1,
        AND   = 4'h2,
        OR    = 4'h3,
        XOR   = 4'h4,
        SHL   = 4'h5,
        SHR   = 4'h6,
        CMP   = 4'h7,  // Flags only, no register write
        ADDI  = 4'h8,
        LOAD  = 4'h9,
        STORE = 4'hA,
        JMP   = 4'hB,
        BEQ   = 4'hC,
        NOP   = 4'hD,
        HALT  = 4'hE
    } opcode_e;

    // Register form, ra is destination and first source
    typedef struct packed {
        opcode_e    opcode;
        logic [3:0] ra;
        logic [3:0] rb;
        logic [3:0] imm4;  // Signed
    } instr_r_t;

    // Jump form, low 12 bits are one signed offset
    typedef struct packed {
        opcode_e     opcode;
        logic [11:0] off12;
    } instr_j_t;

    typedef union packed {
        instr_r_t r;
        instr_j_t j;
    } instr_u;

    // Status word, unused bits read zero
    typedef struct packed {
        logic [7:0] rsvd_hi;
        logic       n;        // Bit 7
        logic       z;        // Bit 6
        logic       f;        // Bit 5
        logic [1:0] rsvd_mid;
        logic       l;        // Bit 2
        logic       rsvd_lo;
        logic       c;        // Bit 0
    } psr_t;

    typedef enum logic [1:0] {
        HOLD_ZERO = 2'd0,  // PC back to 0 on start
        INCR      = 2'd1,
        REL4      = 2'd2,
        REL12     = 2'd3
    } pc_mode_e;

    typedef struct packed {
        logic     wr_en;           // Register file write
        logic     alu_src;         // 1 selects immediate as operand B
        logic     mem_wr_en;       // Port 1 write
        logic     pc_en;
        logic     instr_en;
        logic     cmp_f_en;        // L and N
        logic     of_f_en;         // C and F
        logic     z_f_en;
        pc_mode_e pc_addr_mode;
        logic     write_back_sel;  // 1 selects memory data
        logic     host_own;        // Host owns memory port 2
    } ctrl_t;

    typedef struct packed {
        logic              wr_en;
        logic [9:0]        addr;
        logic [DATA_W-1:0] wr_data;
    } host_req_t;

    typedef enum logic [2:0] {
        ST_IDLE, ST_FETCH, ST_DECODE, ST_EXEC, ST_MEM, ST_HALT
    } state_e;

endpackage

//--- design/cpu_top.sv
// Programs start at address 0; load and read memory over the host port only while idle or halted
`timescale 1ns/1ps

module cpu_top #(
    parameter int MEM_DEPTH = 1024  // Power of two, at most 1024
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        start,         // One-cycle pulse
    input  cpu_pkg::host_req_t          host_req,
    output logic [cpu_pkg::DATA_W-1:0]  host_rd_data,
    output logic                        halted,
    output logic [cpu_pkg::DATA_W-1:0]  alu_out,
    output logic [cpu_pkg::DATA_W-1:0]  mem_data_out,
    output cpu_pkg::opcode_e            opcode,
    output cpu_pkg::psr_t               psr_out
);

    cpu_pkg::ctrl_t  ctrl;
    cpu_pkg::instr_u instr;

    control_fsm i_control_fsm (.clk, .reset, .start, .instr, .psr(psr_out), .ctrl, .halted);

    data_path #(.MEM_DEPTH(MEM_DEPTH)) i_data_path (.clk, .reset, .ctrl, .host_req,
        .host_rd_data, .instr, .psr_out, .alu_out, .mem_data_out, .opcode);

endmodule

//--- design/data_path.sv
// Host owns memory port 2 only while the core is idle or halted; other host writes are dropped
`timescale 1ns/1ps

module data_path #(
    parameter  int MEM_DEPTH = 1024,
    localparam int AW        = $clog2(MEM_DEPTH)
) (
    input  logic                        clk,
    input  logic                        reset,
    input  cpu_pkg::ctrl_t              ctrl,
    input  cpu_pkg::host_req_t          host_req,
    output logic [cpu_pkg::DATA_W-1:0]  host_rd_data,
    output cpu_pkg::instr_u             instr,
    output cpu_pkg::psr_t               psr_out,
    output logic [cpu_pkg::DATA_W-1:0]  alu_out,
    output logic [cpu_pkg::DATA_W-1:0]  mem_data_out,
    output cpu_pkg::opcode_e            opcode
);
    import cpu_pkg::*;

    logic [DATA_W-1:0] reg_data1, reg_data2;
    logic [DATA_W-1:0] immediate, alu_b, alu_result, wb_data;
    logic [DATA_W-1:0] mem_rd_data1, mem_rd_data2;
    logic              c_out, l_out, f_out, z_out, n_out;
    logic [AW-1:0]     pc, p2_addr;
    logic              p2_wr_en;

    instr_reg i_instr_reg (.clk, .reset, .instr_en(ctrl.instr_en),
        .instr_data(mem_rd_data2), .instr);

    reg_file i_reg_file (.clk, .wr_en(ctrl.wr_en), .wr_data(wb_data),
        .addr1(instr.r.ra), .addr2(instr.r.rb), .rd_data1(reg_data1), .rd_data2(reg_data2));

    assign immediate = {{12{instr.r.imm4[3]}}, instr.r.imm4};  // Sign extend
    assign alu_b     = ctrl.alu_src ? immediate : reg_data2;

    alu i_alu (.a(reg_data1), .b(alu_b), .select(instr.r.opcode), .out(alu_result),
        .c(c_out), .l(l_out), .f(f_out), .z(z_out), .n(n_out));

    // Port 2 is the host's when idle or halted, else the fetch port
    assign p2_addr  = ctrl.host_own ? AW'(host_req.addr) : pc;
    assign p2_wr_en = ctrl.host_own & host_req.wr_en;

    unified_memory #(.MEM_DEPTH(MEM_DEPTH)) i_unified_memory (.clk,
        .wr_en1(ctrl.mem_wr_en), .wr_en2(p2_wr_en),
        .addr1(alu_result[AW-1:0]), .addr2(p2_addr),  // Load/store address from the ALU
        .wr_data1(reg_data2), .wr_data2(host_req.wr_data),
        .rd_data1(mem_rd_data1), .rd_data2(mem_rd_data2));

    assign wb_data = ctrl.write_back_sel ? mem_rd_data1 : alu_result;

    status_reg i_status_reg (.clk, .reset, .cmp_f_en(ctrl.cmp_f_en),
        .of_f_en(ctrl.of_f_en), .z_f_en(ctrl.z_f_en), .c_in(c_out), .l_in(l_out),
        .f_in(f_out), .z_in(z_out), .n_in(n_out), .psr(psr_out));

    pc_unit #(.MEM_DEPTH(MEM_DEPTH)) i_pc_unit (.clk, .reset, .pc_en(ctrl.pc_en),
        .mode(ctrl.pc_addr_mode), .instr, .pc);

    assign host_rd_data = mem_rd_data2;  // Valid the cycle after the address
    assign alu_out      = alu_result;
    assign mem_data_out = mem_rd_data1;
    assign opcode       = instr.r.opcode;

    // Host must wait for idle or halted before writing
    a_host_wr_owned: assert property (@(posedge clk) disable iff (reset)
        host_req.wr_en |-> ctrl.host_own)
        else $error("data_path: host write to %0d while core runs", host_req.addr);

endmodule

//--- design/instr_reg.sv
// Holds the word fetched in the previous cycle; resets to NOP so the first decode does nothing
`timescale 1ns/1ps

module instr_reg (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        instr_en,
    input  logic [cpu_pkg::DATA_W-1:0]  instr_data,  // Port 2 read data
    output cpu_pkg::instr_u             instr
);
    import cpu_pkg::*;

    always_ff @(posedge clk) begin
        if (reset) begin
            instr.r <= '{opcode: NOP, default: '0};  // Harmless decode
        end else if (instr_en) begin
            instr <= instr_data;
        end
    end

endmodule

//--- design/pc_unit.sv
// MEM_DEPTH must be a power of two up to 65536; relative targets wrap around the memory
`timescale 1ns/1ps

module pc_unit #(
    parameter  int MEM_DEPTH = 1024,
    localparam int AW        = $clog2(MEM_DEPTH)
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              pc_en,
    input  cpu_pkg::pc_mode_e mode,
    input  cpu_pkg::instr_u   instr,  // Current instruction, both forms used
    output logic [AW-1:0]     pc
);
    import cpu_pkg::*;

    logic [DATA_W-1:0] offset;
    logic [AW-1:0]     pc_next;

    always_comb begin
        case (mode)
            REL4:    offset = {{12{instr.r.imm4[3]}}, instr.r.imm4};
            REL12:   offset = {{4{instr.j.off12[11]}}, instr.j.off12};
            default: offset = DATA_W'(1);  // INCR
        endcase
        // Relative modes add to the PC already incremented in DECODE
        pc_next = (mode == HOLD_ZERO) ? '0 : pc + offset[AW-1:0];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (pc_en) begin
            pc <= pc_next;
        end
    end

endmodule

//--- design/reg_file.sv
// Sixteen registers, contents undefined until written; write always goes to addr1
`timescale 1ns/1ps

module reg_file (
    input  logic                        clk,
    input  logic                        wr_en,
    input  logic [cpu_pkg::DATA_W-1:0]  wr_data,
    input  logic [3:0]                  addr1,     // ra, also the destination
    input  logic [3:0]                  addr2,     // rb
    output logic [cpu_pkg::DATA_W-1:0]  rd_data1,
    output logic [cpu_pkg::DATA_W-1:0]  rd_data2
);
    import cpu_pkg::*;

    logic [DATA_W-1:0] regs [16];

    // Synchronous write
    always_ff @(posedge clk) begin
        if (wr_en) begin
            regs[addr1] <= wr_data;
        end
    end

    // Asynchronous reads
    assign rd_data1 = regs[addr1];
    assign rd_data2 = regs[addr2];

    // Write-back path must carry a defined value, from ALU or memory
    a_wr_data_known: assert property (@(posedge clk) wr_en |-> !$isunknown(wr_data))
        else $error("reg_file: unknown write data to r%0d", addr1);

endmodule

//--- design/status_reg.sv
// Flags load in three groups; bits outside C, L, F, Z and N stay zero
`timescale 1ns/1ps

module status_reg (
    input  logic          clk,
    input  logic          reset,
    input  logic          cmp_f_en,  // L and N
    input  logic          of_f_en,   // C and F
    input  logic          z_f_en,
    input  logic          c_in,
    input  logic          l_in,
    input  logic          f_in,
    input  logic          z_in,
    input  logic          n_in,
    output cpu_pkg::psr_t psr
);

    always_ff @(posedge clk) begin
        if (reset) begin
            psr <= '0;
        end else begin
            if (cmp_f_en) begin
                psr.l <= l_in;
                psr.n <= n_in;
            end
            if (of_f_en) begin
                psr.c <= c_in;
                psr.f <= f_in;
            end
            if (z_f_en) psr.z <= z_in;
        end
    end

endmodule

//--- design/unified_memory.sv
// MEM_DEPTH must be a power of two; reads take one cycle and return old data on a same-cycle write
`timescale 1ns/1ps

module unified_memory #(
    parameter  int MEM_DEPTH = 1024,
    localparam int AW        = $clog2(MEM_DEPTH)
) (
    input  logic                        clk,
    input  logic                        wr_en1,    // Data port
    input  logic                        wr_en2,    // Fetch or host port
    input  logic [AW-1:0]               addr1,
    input  logic [AW-1:0]               addr2,
    input  logic [cpu_pkg::DATA_W-1:0]  wr_data1,
    input  logic [cpu_pkg::DATA_W-1:0]  wr_data2,
    output logic [cpu_pkg::DATA_W-1:0]  rd_data1,
    output logic [cpu_pkg::DATA_W-1:0]  rd_data2
);
    import cpu_pkg::*;

    logic [DATA_W-1:0] mem [MEM_DEPTH];  // Code and data share one array

    always_ff @(posedge clk) begin
        if (wr_en1) begin
            mem[addr1] <= wr_data1;
        end
        if (wr_en2) begin
            mem[addr2] <= wr_data2;
        end
        rd_data1 <= mem[addr1];  // Registered reads
        rd_data2 <= mem[addr2];
    end

    // Host and core never write together, since host writes only while idle or halted
    a_no_write_clash: assert property (
        @(posedge clk) !(wr_en1 && wr_en2 && (addr1 == addr2)))
        else $error("unified_memory: both ports write address %0d", addr1);

endmodule

//--- testbench/tb_cpu_top.sv
// Register file has no reset, so the run zeroes it once by forcing write-back; code at 0, data at 256
`timescale 1ns/1ps

module tb_cpu_top;
    import cpu_pkg::*;

    localparam int CLK_PERIOD      = 100;
    localparam int TOTAL_INSTR     = 438;   // Executed instructions over all programs
    localparam int HOST_CYCLES     = 1000;  // Program loads, preloads and read-backs
    localparam int WATCHDOG_CYCLES = TOTAL_INSTR * 4 * 2 + HOST_CYCLES;
    localparam int DATA_BASE       = 256;   // Held in r15 after base_setup

    logic              clk = 1'b0;
    logic              reset;
    logic              start;
    host_req_t         host_req;
    logic [DATA_W-1:0] host_rd_data;
    logic              halted;
    logic [DATA_W-1:0] alu_out;
    logic [DATA_W-1:0] mem_data_out;
    opcode_e           opcode;
    psr_t              psr_out;

    logic [DATA_W-1:0] prog [$];  // Program being assembled
    logic [DATA_W-1:0] op_a [10];  // Random operand pairs
    logic [DATA_W-1:0] op_b [10];
    int                error_count = 0;

    cpu_top #(.MEM_DEPTH(1024)) i_cpu_top (.clk, .reset, .start, .host_req, .host_rd_data,
        .halted, .alu_out, .mem_data_out, .opcode, .psr_out);

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic stop_with_failure(string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_word(string name, logic [DATA_W-1:0] expected,
                              logic [DATA_W-1:0] actual);
        if (actual !== expected) begin
            error_count++;
            stop_with_failure($sformatf("[FAIL] %s: expected %h, actual %h",
                name, expected, actual));
        end
    endtask

    task automatic check_psr(string name, psr_t expected, psr_t actual);
        if (actual !== expected) begin
            error_count++;
            stop_with_failure($sformatf("[FAIL] %s: expected psr %h, actual %h",
                name, expected, actual));
        end
    endtask

    task automatic check_opcode(string name, opcode_e expected, opcode_e actual);
        if (actual !== expected) begin
            error_count++;
            stop_with_failure($sformatf("[FAIL] %s: expected opcode %s, actual %s (%h)",
                name, expected.name(), actual.name(), actual));
        end
    endtask

    // Register form, ra is also the destination
    task automatic emit(opcode_e op, int ra, int rb, int imm);
        instr_u word;
        word.r = '{opcode: op, ra: 4'(ra), rb: 4'(rb), imm4: 4'(imm)};
        prog.push_back(word);
    endtask

    task automatic emit_jump(int offset);
        instr_u word;
        word.j = '{opcode: JMP, off12: 12'(offset)};
        prog.push_back(word);
    endtask

    // r15 = 1 << 8, r14 is scratch
    task automatic base_setup();
        emit(AND, 15, 0, 0);
        emit(ADDI, 15, 0, 1);
        emit(AND, 14, 0, 0);
        emit(ADDI, 14, 0, 7);
        emit(ADDI, 14, 0, 1);
        emit(SHL, 15, 14, 0);
    endtask

    task automatic load_word(int addr, logic [DATA_W-1:0] data);
        host_req = '{wr_en: 1'b1, addr: 10'(addr), wr_data: data};
        @(negedge clk);
        host_req.wr_en = 1'b0;
    endtask

    task automatic read_word(int addr, output logic [DATA_W-1:0] data);
        host_req = '{wr_en: 1'b0, addr: 10'(addr), wr_data: '0};
        @(negedge clk);  // One-cycle read latency
        data = host_rd_data;
    endtask

    task automatic check_mem(string name, int addr, logic [DATA_W-1:0] expected);
        logic [DATA_W-1:0] actual;
        read_word(addr, actual);
        check_word($sformatf("%s @%0d", name, addr), expected, actual);
    endtask

    task automatic load_program();
        foreach (prog[i]) load_word(i, prog[i]);
        prog.delete();
    endtask

    task automatic run_program();
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        while (!halted) @(negedge clk);  // Watchdog bounds this wait
    endtask

    function automatic logic [DATA_W-1:0] expected_result(opcode_e op, logic [DATA_W-1:0] a,
                                                          logic [DATA_W-1:0] b);
        case (op)
            ADD:     return a + b;
            SUB:     return a - b;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            SHL:     return a << b[3:0];
            SHR:     return a >> b[3:0];  // Logical
            default: return 'x;
        endcase
    endfunction

    task automatic clear_registers();
        for (int i = 0; i < 16; i++) begin
            emit(AND, i, i, 0);
        end
        emit(HALT, 0, 0, 0);
        load_program();
        force i_cpu_top.i_data_path.wb_data = '0;  // Every write lands as zero
        run_program();
        release i_cpu_top.i_data_path.wb_data;
    endtask

    task automatic arith_logic_test();
        opcode_e           ops [7] = '{ADD, SUB, AND, OR, XOR, SHL, SHR};
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        a = DATA_W'(-5 - 4);  // Two ADDI steps from zero
        b = DATA_W'(3);
        base_setup();
        emit(AND, 1, 0, 0);
        emit(ADDI, 1, 0, -5);
        emit(ADDI, 1, 0, -4);
        emit(AND, 2, 0, 0);
        emit(ADDI, 2, 0, 3);
        foreach (ops[k]) begin
            emit(AND, 3, 0, 0);  // Copy r1 into r3
            emit(ADD, 3, 1, 0);
            emit(ops[k], 3, 2, 0);
            emit(STORE, 15, 3, k);
        end
        emit(STORE, 15, 1, 7);  // ADDI result
        emit(HALT, 0, 0, 0);
        load_program();
        run_program();
        foreach (ops[k]) begin
            check_mem($sformatf("arith_%s", ops[k].name()), DATA_BASE + k,
                expected_result(ops[k], a, b));
        end
        check_mem("arith_ADDI", DATA_BASE + 7, a);
    endtask

    // r5 holds 0x8000 from flags_test
    task automatic compare_case(string name, int a, int b, logic lower_u, logic lower_s,
                                logic equal);
        psr_t expected;
        expected   = '0;
        expected.c = 1'b1;  // From doubling 0x8000 just before the CMP
        expected.f = 1'b1;
        expected.l = lower_u;
        expected.n = lower_s;
        expected.z = equal;
        emit(AND, 1, 0, 0);
        emit(ADDI, 1, 0, a);
        emit(AND, 2, 0, 0);
        emit(ADDI, 2, 0, b);
        emit(AND, 6, 0, 0);
        emit(ADD, 6, 5, 0);
        emit(ADD, 6, 5, 0);  // Sets C and F again
        emit(CMP, 1, 2, 0);
        emit(HALT, 0, 0, 0);
        load_program();
        run_program();
        check_psr(name, expected, psr_out);
    endtask

    task automatic flags_test();
        psr_t flags;
        flags = '0;
        // 0xFFFF >> 1 = 0x7FFF, plus 1 = 0x8000, doubled wraps to zero
        emit(AND, 1, 0, 0);
        emit(ADDI, 1, 0, -1);
        emit(AND, 2, 0, 0);
        emit(ADDI, 2, 0, 1);
        emit(SHR, 1, 2, 0);
        emit(ADD, 1, 2, 0);
        emit(AND, 5, 0, 0);  // Keep 0x8000 in r5
        emit(ADD, 5, 1, 0);
        emit(ADD, 1, 1, 0);
        emit(HALT, 0, 0, 0);
        load_program();
        run_program();
        flags.c = 1'b1;  // Carry out of bit 15
        flags.f = 1'b1;  // Two negatives gave a positive
        flags.z = 1'b1;
        check_psr("add_overflow", flags, psr_out);
        compare_case("cmp_equal", 5, 5, 1'b0, 1'b0, 1'b1);
        compare_case("cmp_lower", 3, 5, 1'b1, 1'b1, 1'b0);
        compare_case("cmp_negative", -1, 5, 1'b0, 1'b1, 1'b0);  // 0xFFFF is above 5 unsigned
    endtask

    task automatic load_store_test();
        logic [DATA_W-1:0] data [4] = '{16'h1234, 16'hFFFE, 16'h8000, 16'h0F0F};
        foreach (data[k]) load_word(DATA_BASE + k, data[k]);
        base_setup();
        foreach (data[k]) begin
            emit(AND, 3, 0, 0);
            emit(ADD, 3, 15, 0);  // Load address comes from ra
            emit(LOAD, 3, 0, k);
            emit(ADDI, 3, 0, 3);
            emit(STORE, 15, 3, k + 4);
        end
        emit(HALT, 0, 0, 0);
        load_program();
        run_program();
        foreach (data[k]) check_mem("load_store", DATA_BASE + 4 + k, data[k] + DATA_W'(3));
    endtask

    task automatic control_flow_test();
        int sum;
        sum = 0;
        for (int i = 1; i <= 5; i++) begin
            sum += i;
        end
        base_setup();
        emit(AND, 1, 0, 0);
        emit(ADDI, 1, 0, 5);  // Counter
        emit(AND, 2, 0, 0);  // Running sum
        emit(CMP, 1, 0, 0);  // Loop head
        emit(BEQ, 0, 0, 3);  // Exit to the STORE
        emit(ADD, 2, 1, 0);
        emit(ADDI, 1, 0, -1);
        emit_jump(-5);  // Back to CMP
        emit(STORE, 15, 2, 0);
        emit(HALT, 15, 0, 0);  // ALU keeps adding r15 and r0 while halted
        load_program();
        run_program();
        check_opcode("control_flow", HALT, opcode);
        check_word("control_flow_alu", DATA_W'(DATA_BASE), alu_out);
        check_word("control_flow_port1", DATA_W'(sum), mem_data_out);  // Port 1 reads mem[r15]
        check_mem("control_flow", DATA_BASE, DATA_W'(sum));
    endtask

    task automatic load_pairs();
        foreach (op_a[i]) begin
            load_word(DATA_BASE + 2 * i, op_a[i]);
            load_word(DATA_BASE + 2 * i + 1, op_b[i]);
        end
    endtask

    // Sum overwrites a, difference overwrites b
    task automatic check_pairs(string name);
        foreach (op_a[i]) begin
            check_mem(name, DATA_BASE + 2 * i, op_a[i] + op_b[i]);
            check_mem(name, DATA_BASE + 2 * i + 1, op_a[i] - op_b[i]);
        end
    endtask

    task automatic random_test();
        foreach (op_a[i]) begin
            op_a[i] = DATA_W'($urandom);
            op_b[i] = DATA_W'($urandom);
        end
        load_pairs();
        base_setup();
        emit(AND, 4, 0, 0);
        emit(ADD, 4, 15, 0);  // r4 walks the pairs
        foreach (op_a[i]) begin
            emit(AND, 1, 0, 0);
            emit(ADD, 1, 4, 0);
            emit(LOAD, 1, 0, 0);
            emit(AND, 2, 0, 0);
            emit(ADD, 2, 4, 0);
            emit(LOAD, 2, 0, 1);
            emit(AND, 3, 0, 0);
            emit(ADD, 3, 1, 0);
            emit(ADD, 3, 2, 0);  // a + b
            emit(SUB, 1, 2, 0);  // a - b
            emit(STORE, 4, 3, 0);
            emit(STORE, 4, 1, 1);
            emit(ADDI, 4, 0, 2);
        end
        emit(HALT, 0, 0, 0);
        load_program();
        run_program();
        check_pairs("random_operands");
    endtask

    task automatic restart_test();
        op_a[0] = DATA_W'($urandom);  // New first pair, written while halted
        op_b[0] = DATA_W'($urandom);
        load_pairs();
        run_program();  // Same program, still in memory
        check_pairs("restart");
    endtask

    initial begin
        void'($urandom(32'h743a1bb0));
        reset    = 1'b1;
        start    = 1'b0;
        host_req = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        clear_registers();
        arith_logic_test();
        flags_test();
        load_store_test();
        control_flow_test();
        random_test();
        restart_test();
        if (error_count == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            stop_with_failure("Checks failed before the end of the run");
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        stop_with_failure($sformatf("Processor never halted within %0d cycles",
            WATCHDOG_CYCLES));
    end

endmodule

//--- verilog.f
design/cpu_pkg.sv
design/instr_reg.sv
design/reg_file.sv
design/alu.sv
design/unified_memory.sv
design/status_reg.sv
design/pc_unit.sv
design/control_fsm.sv
design/data_path.sv
design/cpu_top.sv
testbench/tb_cpu_top.sv
